//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module maxflow_tb -f sim.f -o maxflow_sim

run: compile
	./obj_dir/maxflow_sim > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Finished with no errors" sim.log; then echo "simulation FAILED"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf obj_dir sim.log

//--- hw/maxflow_header_loader.sv
`timescale 1ns/100ps

module maxflow_header_loader (
   input  logic                       clk,
   input  logic                       rstn,
   input  maxflow_pkg::rd_rsp_t       rd_rsp,
   input  logic                       rd_rsp_valid,
   input  logic                       rd_rsp_ready,
   input  logic                       header_phase,
   output maxflow_pkg::graph_header_t header,
   output logic                       hdr_valid
);

   logic [1:0] beat_cnt; // next header beat
   logic       beat;

   assign beat = header_phase & rd_rsp_valid & rd_rsp_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         beat_cnt  <= 2'd0;
         hdr_valid <= 1'b0;
      end else begin
         if (beat && beat_cnt != 2'd2) begin
            beat_cnt <= beat_cnt + 2'd1;
         end
         if (beat_cnt == 2'd2) begin
            hdr_valid <= 1'b1; // sticky until reset
         end
      end
   end

   always_ff @(posedge clk) begin
      if (beat) begin
         case (beat_cnt)
            2'd0: header.vertex_base <= rd_rsp.data[31:0];
            2'd1: begin
               header.source_vid <= rd_rsp.data[31:0];
               header.sink_vid   <= rd_rsp.data[63:32];
            end
            default: ;
         endcase
      end
   end

endmodule

//--- hw/maxflow_pkg.sv
package maxflow_pkg;

   typedef enum logic [3:0] {
      DISCHARGE_TASK  = 4'd0,
      GET_HEIGHT_TASK = 4'd1,
      PUSH_TASK       = 4'd2,
      RECEIVE_TASK    = 4'd3
   } task_ttype_e;

   typedef struct packed {
      logic [63:0] args;   // arg1 high half, arg0 low half
      task_ttype_e ttype;
      logic [31:0] locale; // vertex id
      logic [31:0] ts;
   } task_t;

   typedef struct packed {
      logic [31:0] addr;
      logic [3:0]  len;    // beats minus one
   } rd_req_t;

   typedef struct packed {
      logic [63:0] data;
      logic        last;
   } rd_rsp_t;

   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] data;
   } wr_req_t;

   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] old_data;
   } undo_entry_t;

   typedef struct packed {
      logic [31:0] vertex_base;
      logic [31:0] source_vid;
      logic [31:0] sink_vid;
   } graph_header_t;

   // byte offsets inside a vertex record
   localparam logic [31:0] VID_EXCESS_OFFSET = 32'd0;
   localparam logic [31:0] VID_HEIGHT_OFFSET = 32'd8;
   localparam logic [31:0] VID_FLOW_OFFSET   = 32'd16; // flow slots, 4 bytes apart

   localparam logic [31:0] HEADER_ADDR = 32'd0;

   typedef enum logic [4:0] {
      ST_IDLE,
      ST_READ_HEADER, ST_WAIT_HEADER,
      ST_GH_READ_HEIGHT, ST_GH_WAIT_HEIGHT, ST_GH_ENQ_PUSH,
      ST_RCV_READ_EXCESS, ST_RCV_WAIT_EXCESS,
      ST_RCV_READ_FLOW, ST_RCV_WAIT_FLOW,
      ST_RCV_UNDO_FLOW, ST_RCV_WRITE_FLOW,
      ST_RCV_UNDO_EXCESS, ST_RCV_WRITE_EXCESS,
      ST_RCV_ENQ_DISCHARGE,
      ST_FINISH
   } fsm_state_e;

endpackage

//--- hw/maxflow_read_capture.sv
`timescale 1ns/100ps

module maxflow_read_capture (
   input  logic                    clk,
   input  maxflow_pkg::rd_rsp_t    rd_rsp,
   input  logic                    rd_rsp_valid,
   input  logic                    rd_rsp_ready,
   input  maxflow_pkg::fsm_state_e capture_sel,
   output logic signed [31:0]      excess,
   output logic [31:0]             height,
   output logic signed [31:0]      flow
);

   import maxflow_pkg::*;

   logic        xfer;
   logic [31:0] word;

   assign xfer = rd_rsp_valid & rd_rsp_ready;
   assign word = rd_rsp.data[31:0]; // single word reads use the low half

   always_ff @(posedge clk) begin
      if (xfer) begin
         case (capture_sel)
            ST_GH_WAIT_HEIGHT: begin
               height <= word;
            end
            ST_RCV_WAIT_EXCESS: begin
               excess <= $signed(word);
            end
            ST_RCV_WAIT_FLOW: begin
               flow <= $signed(word);
            end
            default: ; // header beats go to the loader
         endcase
      end
   end

endmodule

//--- hw/maxflow_task_fsm.sv
`timescale 1ns/100ps

module maxflow_task_fsm #(
   parameter int vertex_shift = 6
) (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic                       start,
   input  maxflow_pkg::task_t         task_in,
   input  maxflow_pkg::graph_header_t header,
   input  logic                       hdr_valid,
   input  logic signed [31:0]         excess,
   input  logic [31:0]                height,
   input  logic signed [31:0]         flow,
   input  logic                       rd_rsp_valid,
   input  maxflow_pkg::rd_rsp_t       rd_rsp,
   input  logic                       rd_req_ready,
   input  logic                       wr_ready,
   input  logic                       undo_ready,
   input  logic                       task_out_ready,
   output logic                       done,
   output logic                       idle,
   output logic                       header_phase,
   output maxflow_pkg::fsm_state_e    capture_sel,
   output logic                       rd_rsp_ready,
   output maxflow_pkg::rd_req_t       rd_req,
   output logic                       rd_req_valid,
   output maxflow_pkg::wr_req_t       wr_req,
   output logic                       wr_valid,
   output maxflow_pkg::undo_entry_t   undo,
   output logic                       undo_valid,
   output maxflow_pkg::task_t         task_out,
   output logic                       task_out_valid
);

   import maxflow_pkg::*;

   fsm_state_e         state, state_next, begin_state;
   task_t              cur_task;
   logic [31:0]        arg0;
   logic signed [31:0] arg1;
   logic [31:0]        vertex_addr, height_addr, excess_addr, flow_addr;
   logic               rsp_done;

   assign cur_task = task_in; // held stable until done
   assign arg0     = cur_task.args[31:0];
   assign arg1     = cur_task.args[63:32];

   assign vertex_addr = header.vertex_base + (cur_task.locale << vertex_shift);
   assign height_addr = vertex_addr + VID_HEIGHT_OFFSET;
   assign excess_addr = vertex_addr + VID_EXCESS_OFFSET;
   assign flow_addr   = vertex_addr + VID_FLOW_OFFSET + {26'd0, arg0[3:0], 2'b00};

   assign rsp_done = rd_rsp_valid & rd_rsp_ready & rd_rsp.last;

   assign done         = (state == ST_FINISH);
   assign idle         = (state == ST_IDLE);
   assign header_phase = (state == ST_WAIT_HEADER);
   assign capture_sel  = state;
   assign rd_rsp_ready = (state == ST_WAIT_HEADER) | (state == ST_GH_WAIT_HEIGHT)
                       | (state == ST_RCV_WAIT_EXCESS) | (state == ST_RCV_WAIT_FLOW);

   always_comb begin
      case (cur_task.ttype)
         GET_HEIGHT_TASK: begin_state = ST_GH_READ_HEIGHT;
         RECEIVE_TASK:    begin_state = ST_RCV_READ_EXCESS;
         default:         begin_state = ST_FINISH; // nothing to do
      endcase
   end

   always_comb begin
      state_next     = state;
      rd_req         = '0;
      rd_req_valid   = 1'b0;
      wr_req         = '0;
      wr_valid       = 1'b0;
      undo           = '0;
      undo_valid     = 1'b0;
      task_out       = '0;
      task_out_valid = 1'b0;

      case (state)
         ST_IDLE: begin
            if (start) begin
               state_next = hdr_valid ? begin_state : ST_READ_HEADER;
            end
         end
         ST_READ_HEADER: begin
            rd_req.addr  = HEADER_ADDR;
            rd_req.len   = 4'd1; // two beats
            rd_req_valid = 1'b1;
            if (rd_req_ready) begin
               state_next = ST_WAIT_HEADER;
            end
         end
         ST_GH_READ_HEIGHT: begin
            rd_req.addr  = height_addr;
            rd_req_valid = 1'b1;
            if (rd_req_ready) begin
               state_next = ST_GH_WAIT_HEIGHT;
            end
         end
         ST_GH_ENQ_PUSH: begin
            task_out.ttype  = PUSH_TASK;
            task_out.locale = arg0;
            task_out.args   = {arg1, height};
            task_out.ts     = cur_task.ts;
            task_out_valid  = 1'b1;
            if (task_out_ready) begin
               state_next = ST_FINISH;
            end
         end
         ST_RCV_READ_EXCESS: begin
            rd_req.addr  = excess_addr;
            rd_req_valid = 1'b1;
            if (rd_req_ready) begin
               state_next = ST_RCV_WAIT_EXCESS;
            end
         end
         ST_RCV_READ_FLOW: begin
            rd_req.addr  = flow_addr;
            rd_req_valid = 1'b1;
            if (rd_req_ready) begin
               state_next = ST_RCV_WAIT_FLOW;
            end
         end
         ST_RCV_UNDO_FLOW: begin
            undo.addr     = flow_addr;
            undo.old_data = flow;
            undo_valid    = 1'b1;
            if (undo_ready) begin
               state_next = ST_RCV_WRITE_FLOW;
            end
         end
         ST_RCV_WRITE_FLOW: begin
            wr_req.addr = flow_addr;
            wr_req.data = flow - arg1; // reverse direction of the push
            wr_valid    = 1'b1;
            if (wr_ready) begin
               state_next = ST_RCV_UNDO_EXCESS;
            end
         end
         ST_RCV_UNDO_EXCESS: begin
            undo.addr     = excess_addr;
            undo.old_data = excess;
            undo_valid    = 1'b1;
            if (undo_ready) begin
               state_next = ST_RCV_WRITE_EXCESS;
            end
         end
         ST_RCV_WRITE_EXCESS: begin
            wr_req.addr = excess_addr;
            wr_req.data = excess + arg1;
            wr_valid    = 1'b1;
            if (wr_ready) begin
               // vertex just became active
               if (excess == 32'sd0 && cur_task.locale != header.source_vid
                   && cur_task.locale != header.sink_vid) begin
                  state_next = ST_RCV_ENQ_DISCHARGE;
               end else begin
                  state_next = ST_FINISH;
               end
            end
         end
         ST_RCV_ENQ_DISCHARGE: begin
            task_out.ttype  = DISCHARGE_TASK;
            task_out.locale = cur_task.locale;
            task_out.args   = {cur_task.ts, 32'd0};
            task_out.ts     = cur_task.ts;
            task_out_valid  = 1'b1;
            if (task_out_ready) begin
               state_next = ST_FINISH;
            end
         end
         ST_WAIT_HEADER:     if (rsp_done) state_next = begin_state;
         ST_GH_WAIT_HEIGHT:  if (rsp_done) state_next = ST_GH_ENQ_PUSH;
         ST_RCV_WAIT_EXCESS: if (rsp_done) state_next = ST_RCV_READ_FLOW;
         ST_RCV_WAIT_FLOW:   if (rsp_done) state_next = ST_RCV_UNDO_FLOW;
         ST_FINISH:          state_next = ST_IDLE;
         default:            state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= ST_IDLE;
      end else begin
         state <= state_next;
      end
   end

endmodule

//--- hw/maxflow_top.sv
`timescale 1ns/100ps

module maxflow_top #(
   parameter int vertex_shift = 6
) (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     start,
   output logic                     done,
   output logic                     idle,
   input  maxflow_pkg::task_t       task_in,
   output maxflow_pkg::rd_req_t     rd_req,
   output logic                     rd_req_valid,
   input  logic                     rd_req_ready,
   input  maxflow_pkg::rd_rsp_t     rd_rsp,
   input  logic                     rd_rsp_valid,
   output logic                     rd_rsp_ready,
   output maxflow_pkg::wr_req_t     wr_req,
   output logic                     wr_valid,
   input  logic                     wr_ready,
   output maxflow_pkg::undo_entry_t undo,
   output logic                     undo_valid,
   input  logic                     undo_ready,
   output maxflow_pkg::task_t       task_out,
   output logic                     task_out_valid,
   input  logic                     task_out_ready
);

   import maxflow_pkg::*;

   graph_header_t      header;
   logic               hdr_valid;
   logic               header_phase;
   fsm_state_e         capture_sel;
   logic signed [31:0] excess;
   logic [31:0]        height;
   logic signed [31:0] flow;

   maxflow_header_loader u_header_loader (
      .clk          (clk),
      .rstn         (rstn),
      .rd_rsp       (rd_rsp),
      .rd_rsp_valid (rd_rsp_valid),
      .rd_rsp_ready (rd_rsp_ready),
      .header_phase (header_phase),
      .header       (header),
      .hdr_valid    (hdr_valid)
   );

   maxflow_read_capture u_read_capture (
      .clk          (clk),
      .rd_rsp       (rd_rsp),
      .rd_rsp_valid (rd_rsp_valid),
      .rd_rsp_ready (rd_rsp_ready),
      .capture_sel  (capture_sel),
      .excess       (excess),
      .height       (height),
      .flow         (flow)
   );

   maxflow_task_fsm #(
      .vertex_shift (vertex_shift)
   ) u_task_fsm (
      .clk            (clk),
      .rstn           (rstn),
      .start          (start),
      .task_in        (task_in),
      .header         (header),
      .hdr_valid      (hdr_valid),
      .excess         (excess),
      .height         (height),
      .flow           (flow),
      .rd_rsp_valid   (rd_rsp_valid),
      .rd_rsp         (rd_rsp),
      .rd_req_ready   (rd_req_ready),
      .wr_ready       (wr_ready),
      .undo_ready     (undo_ready),
      .task_out_ready (task_out_ready),
      .done           (done),
      .idle           (idle),
      .header_phase   (header_phase),
      .capture_sel    (capture_sel),
      .rd_rsp_ready   (rd_rsp_ready),
      .rd_req         (rd_req),
      .rd_req_valid   (rd_req_valid),
      .wr_req         (wr_req),
      .wr_valid       (wr_valid),
      .undo           (undo),
      .undo_valid     (undo_valid),
      .task_out       (task_out),
      .task_out_valid (task_out_valid)
   );

endmodule

//--- sim.f
hw/maxflow_pkg.sv
hw/maxflow_header_loader.sv
hw/maxflow_read_capture.sv
hw/maxflow_task_fsm.sv
hw/maxflow_top.sv
verification/maxflow_checker.sv
verification/maxflow_tb.sv

//--- verification/maxflow_cases.txt
# hdr <vertex_base> <source_vid> <sink_vid> ; case <name> <ts> <locale> <ttype> <args> ; mem <addr> <data>
# expected: reads <n> ; undo <addr> <old> ; task <ts> <locale> <ttype> <args> ; word <addr> <data> ; end
hdr 00001000 00000000 00000007
case gh_first 00000010 00000003 1 0000005500000005 mem 000010c8 0000000c
   reads 2 task 00000010 00000005 2 000000550000000c end
case gh_again 00000011 00000004 1 0000000700000002 mem 00001108 00000021
   reads 1 task 00000011 00000002 2 0000000700000021 end
case rcv_pos 00000020 00000002 3 0000000300000003 mem 00001080 00000010 mem 0000109c 00000005
   reads 2 undo 0000109c 00000005 undo 00001080 00000010
   word 0000109c 00000002 word 00001080 00000013 end
case rcv_act 00000021 00000005 3 0000000400000000 mem 00001140 00000000 mem 00001150 00000000
   reads 2 undo 00001150 00000000 undo 00001140 00000000
   word 00001150 fffffffc word 00001140 00000004
   task 00000021 00000005 0 0000002100000000 end
case rcv_sink 00000022 00000007 3 0000000200000001 mem 000011c0 00000000 mem 000011d4 00000009
   reads 2 undo 000011d4 00000009 undo 000011c0 00000000
   word 000011d4 00000007 word 000011c0 00000002 end
case rcv_src 00000023 00000000 3 000000010000000f mem 00001000 00000000 mem 0000104c 00000020
   reads 2 undo 0000104c 00000020 undo 00001000 00000000
   word 0000104c 0000001f word 00001000 00000001 end
case bad_op 00000030 00000001 9 0000000000000000
   reads 0 end

//--- verification/maxflow_checker.sv
`timescale 1ns/100ps

module maxflow_checker (
   input logic                     clk,
   input logic                     rstn,
   input maxflow_pkg::rd_req_t     rd_req,
   input logic                     rd_req_valid,
   input logic                     rd_req_ready,
   input maxflow_pkg::wr_req_t     wr_req,
   input logic                     wr_valid,
   input logic                     wr_ready,
   input maxflow_pkg::undo_entry_t undo,
   input logic                     undo_valid,
   input logic                     undo_ready,
   input maxflow_pkg::task_t       task_out,
   input logic                     task_out_valid,
   input logic                     task_out_ready
);

   logic        undo_seen;   // logged, write still to come
   logic [31:0] undo_addr_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         undo_seen <= 1'b0;
      end else if (undo_valid && undo_ready) begin
         undo_seen   <= 1'b1;
         undo_addr_q <= undo.addr;
      end else if (wr_valid && wr_ready) begin
         undo_seen <= 1'b0;
      end
   end

   assert property (@(posedge clk) disable iff (!rstn)
      rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req))
      else $error("read request dropped or changed while stalled");

   assert property (@(posedge clk) disable iff (!rstn)
      wr_valid && !wr_ready |=> wr_valid && $stable(wr_req))
      else $error("write request dropped or changed while stalled");

   assert property (@(posedge clk) disable iff (!rstn)
      undo_valid && !undo_ready |=> undo_valid && $stable(undo))
      else $error("undo entry dropped or changed while stalled");

   assert property (@(posedge clk) disable iff (!rstn)
      task_out_valid && !task_out_ready |=> task_out_valid && $stable(task_out))
      else $error("emitted task dropped or changed while stalled");

   assert property (@(posedge clk) disable iff (!rstn)
      $onehot0({rd_req_valid, wr_valid, undo_valid, task_out_valid}))
      else $error("more than one request channel valid at once");

   assert property (@(posedge clk) disable iff (!rstn)
      wr_valid |-> undo_seen && undo_addr_q == wr_req.addr)
      else $error("write issued without an undo entry for its address");

endmodule

bind maxflow_task_fsm maxflow_checker u_checker (
   .clk            (clk),
   .rstn           (rstn),
   .rd_req         (rd_req),
   .rd_req_valid   (rd_req_valid),
   .rd_req_ready   (rd_req_ready),
   .wr_req         (wr_req),
   .wr_valid       (wr_valid),
   .wr_ready       (wr_ready),
   .undo           (undo),
   .undo_valid     (undo_valid),
   .undo_ready     (undo_ready),
   .task_out       (task_out),
   .task_out_valid (task_out_valid),
   .task_out_ready (task_out_ready)
);

//--- verification/maxflow_tb.sv
`timescale 1ns/100ps

module maxflow_tb;

   import maxflow_pkg::*;

   localparam int TIMEOUT_CYCLES = 1000;

   logic        clk = 1'b0;
   logic        rstn;
   logic        start;
   logic        done;
   logic        idle;
   task_t       task_in;
   task_t       next_task;
   rd_req_t     rd_req;
   logic        rd_req_valid;
   logic        rd_req_ready;
   rd_rsp_t     rd_rsp;
   logic        rd_rsp_valid;
   logic        rd_rsp_ready;
   wr_req_t     wr_req;
   logic        wr_valid;
   logic        wr_ready;
   undo_entry_t undo;
   logic        undo_valid;
   logic        undo_ready;
   task_t       task_out;
   logic        task_out_valid;
   logic        task_out_ready;

   logic [31:0] mem [logic [31:0]]; // byte addressed words
   logic [31:0] lfsr = 32'ha5a8e287;
   string       case_name;
   int          rd_cnt;
   int          wr_cnt;
   int          undo_cnt;
   int          task_cnt;
   int          exp_reads;
   undo_entry_t exp_undo[$];
   task_t       exp_task[$];
   logic [31:0] exp_addr[$];
   logic [31:0] exp_data[$];

   logic        rsp_active = 1'b0; // read burst being answered
   logic        rsp_fire = 1'b0;   // beat transfers on next rising edge
   logic [31:0] rsp_addr;
   logic [3:0]  rsp_left;

   maxflow_top #(
      .vertex_shift (6)
   ) dut (
      .clk            (clk),
      .rstn           (rstn),
      .start          (start),
      .done           (done),
      .idle           (idle),
      .task_in        (task_in),
      .rd_req         (rd_req),
      .rd_req_valid   (rd_req_valid),
      .rd_req_ready   (rd_req_ready),
      .rd_rsp         (rd_rsp),
      .rd_rsp_valid   (rd_rsp_valid),
      .rd_rsp_ready   (rd_rsp_ready),
      .wr_req         (wr_req),
      .wr_valid       (wr_valid),
      .wr_ready       (wr_ready),
      .undo           (undo),
      .undo_valid     (undo_valid),
      .undo_ready     (undo_ready),
      .task_out       (task_out),
      .task_out_valid (task_out_valid),
      .task_out_ready (task_out_ready)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
   endfunction

   function automatic logic take_bit();
      lfsr = lfsr_step(lfsr);
      return lfsr[0];
   endfunction

   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      if (mem.exists(addr)) begin
         return mem[addr];
      end
      return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3; // never written
   endfunction

   task automatic report_failure(input string msg);
      $display("%0s", msg);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_task(input task_t exp, input task_t act);
      if (act !== exp) begin
         report_failure($sformatf("Mismatch %0s task_out: expected %h, actual %h",
                                  case_name, exp, act));
      end
   endtask

   task automatic check_undo(input undo_entry_t exp, input undo_entry_t act);
      if (act !== exp) begin
         report_failure($sformatf("Mismatch %0s undo: expected %h, actual %h",
                                  case_name, exp, act));
      end
   endtask

   task automatic check_word(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
      if (act !== exp) begin
         report_failure($sformatf("Mismatch %0s %0s: expected %h, actual %h",
                                  case_name, what, exp, act));
      end
   endtask

   // memory, undo log and task sink, all driven on the falling edge
   always @(negedge clk) begin
      if (rstn) begin
         if (rsp_fire) begin
            rsp_fire     = 1'b0;
            rd_rsp_valid = 1'b0;
            rsp_addr     = rsp_addr + 32'd8;
            if (rsp_left == 4'd0) begin
               rsp_active = 1'b0;
            end else begin
               rsp_left = rsp_left - 4'd1;
            end
         end
         if (rsp_active && !rd_rsp_valid && take_bit()) begin
            rd_rsp_valid = 1'b1;
            rd_rsp.data  = {mem_word(rsp_addr + 32'd4), mem_word(rsp_addr)};
            rd_rsp.last  = (rsp_left == 4'd0);
         end
         if (rd_rsp_valid && rd_rsp_ready) begin
            rsp_fire = 1'b1;
         end
         rd_req_ready = take_bit();
         if (rd_req_valid && rd_req_ready) begin
            rsp_active = 1'b1;
            rsp_addr   = rd_req.addr;
            rsp_left   = rd_req.len;
            rd_cnt++;
         end
         wr_ready = take_bit();
         if (wr_valid && wr_ready) begin
            mem[wr_req.addr] = wr_req.data;
            wr_cnt++;
         end
         undo_ready = take_bit();
         if (undo_valid && undo_ready) begin
            if (undo_cnt < exp_undo.size()) begin
               check_undo(exp_undo[undo_cnt], undo);
            end else begin
               report_failure($sformatf("%0s: undo entry that was not expected", case_name));
            end
            undo_cnt++;
         end
         task_out_ready = take_bit();
         if (task_out_valid && task_out_ready) begin
            if (task_cnt < exp_task.size()) begin
               check_task(exp_task[task_cnt], task_out);
            end else begin
               report_failure($sformatf("%0s: task emitted that was not expected", case_name));
            end
            task_cnt++;
         end
      end
   end

   task automatic run_case();
      int cycles;
      rd_cnt   = 0;
      wr_cnt   = 0;
      undo_cnt = 0;
      task_cnt = 0;
      cycles   = 0;
      @(negedge clk);
      task_in = next_task;
      start   = 1'b1;
      @(negedge clk);
      start = 1'b0;
      while (!done) begin
         if (cycles == TIMEOUT_CYCLES) begin
            report_failure($sformatf("%0s: timed out waiting for done", case_name));
         end
         @(negedge clk);
         cycles++;
      end
      @(negedge clk);
      if (!idle) begin
         report_failure($sformatf("%0s: idle did not return after done", case_name));
      end
      check_word("read requests", exp_reads, rd_cnt);
      check_word("undo entries", exp_undo.size(), undo_cnt);
      check_word("writes", exp_undo.size(), wr_cnt); // one write per undo entry
      check_word("emitted tasks", exp_task.size(), task_cnt);
      foreach (exp_addr[i]) begin
         check_word($sformatf("word %h", exp_addr[i]), exp_data[i], mem_word(exp_addr[i]));
      end
   endtask

   initial begin
      int               fd;
      int               n;
      string            kw;
      logic [31:0]      a;
      logic [31:0]      b;
      logic [31:0]      c;
      logic [3:0]       tt;
      logic [63:0]      args;
      logic [8*160-1:0] line;
      task_t            t;
      undo_entry_t      u;
      rstn           = 1'b0;
      start          = 1'b0;
      task_in        = '0;
      next_task      = '0;
      rd_req_ready   = 1'b0;
      rd_rsp         = '0;
      rd_rsp_valid   = 1'b0;
      wr_ready       = 1'b0;
      undo_ready     = 1'b0;
      task_out_ready = 1'b0;
      case_name      = "reset";
      fd = $fopen("verification/maxflow_cases.txt", "r");
      if (fd == 0) begin
         report_failure("could not open verification/maxflow_cases.txt");
      end
      repeat (2) @(negedge clk);
      rstn = 1'b1;
      @(negedge clk);
      if (!idle) begin
         report_failure("idle is low after reset");
      end
      while ($fscanf(fd, "%s", kw) == 1) begin
         if (kw == "#") begin
            n = $fgets(line, fd); // rest of a comment line
         end else if (kw == "hdr") begin
            n = $fscanf(fd, "%h %h %h", a, b, c);
            mem[HEADER_ADDR]          = a;
            mem[HEADER_ADDR + 32'd8]  = b;
            mem[HEADER_ADDR + 32'd12] = c;
         end else if (kw == "case") begin
            n = $fscanf(fd, "%s %h %h %h %h", case_name, a, b, tt, args);
            next_task.ts     = a;
            next_task.locale = b;
            next_task.ttype  = task_ttype_e'(tt);
            next_task.args   = args;
            exp_reads        = 0;
            exp_undo.delete();
            exp_task.delete();
            exp_addr.delete();
            exp_data.delete();
         end else if (kw == "mem") begin
            n = $fscanf(fd, "%h %h", a, b);
            mem[a] = b;
         end else if (kw == "reads") begin
            n = $fscanf(fd, "%d", exp_reads);
         end else if (kw == "undo") begin
            n = $fscanf(fd, "%h %h", a, b);
            u.addr     = a;
            u.old_data = b;
            exp_undo.push_back(u);
         end else if (kw == "task") begin
            n = $fscanf(fd, "%h %h %h %h", a, b, tt, args);
            t.ts     = a;
            t.locale = b;
            t.ttype  = task_ttype_e'(tt);
            t.args   = args;
            exp_task.push_back(t);
         end else if (kw == "word") begin
            n = $fscanf(fd, "%h %h", a, b);
            exp_addr.push_back(a);
            exp_data.push_back(b);
         end else if (kw == "end") begin
            run_case();
         end else begin
            report_failure($sformatf("unknown keyword %0s in the cases file", kw));
         end
      end
      $fclose(fd);
      $display("Finished with no errors");
      $finish;
   end

endmodule
